// File: common/sonic_pkg.sv
// ring geometry, datapath widths and the oword type shared by the tx circular buffer
`default_nettype none

package sonic_pkg;

	// --------------------------------------------------
	// ring geometry
	// --------------------------------------------------
	// 16 owords of 128 bits
	localparam int TX_WRITE_ADDR_WIDTH = 4;
	// same ring seen as 32 qwords
	localparam int TX_READ_ADDR_WIDTH = 5;
	// one extra bit so a count of 32 fits
	localparam int USED_QWORDS_WIDTH = 6;

	localparam logic [USED_QWORDS_WIDTH-1:0] RING_DEPTH_QWORDS = 6'd32;
	// write side flag threshold, at or above
	localparam logic [USED_QWORDS_WIDTH-1:0] ALMOST_FULL_QWORDS = 6'd28;
	// read side flag threshold, at or below
	localparam logic [USED_QWORDS_WIDTH-1:0] ALMOST_EMPTY_QWORDS = 6'd4;

	// flops on the completion toggle path
	localparam int CPL_SYNC_STAGES = 8;

	// --------------------------------------------------
	// datapath widths
	// --------------------------------------------------
	localparam int INPUT_WIDTH = 128;
	localparam int BUFFER_WIDTH = 64;
	localparam int OUTPUT_WIDTH = 40;

	// worst case gearbox stream
	// 39 held bits plus one fresh qword
	localparam int GEARBOX_RESIDUE_WIDTH = OUTPUT_WIDTH + BUFFER_WIDTH - 1;
	// bit count up to 103
	localparam int GEARBOX_COUNT_WIDTH = 7;

	// oword as written by the host, read back as two qwords
	// qword 0 sits in the low half and leaves first
	typedef union packed {
		logic [INPUT_WIDTH-1:0] oword;
		logic [INPUT_WIDTH/BUFFER_WIDTH-1:0][BUFFER_WIDTH-1:0] qword;
	} tx_oword_u;

endpackage

`default_nettype wire

// File: verilog/sonic_dpram_async.sv
// dual clock ring memory, written an oword at a time and read back a qword at a time
`timescale 1ns/1ps
`default_nettype none

module sonic_dpram_async (
	// write port
	input logic wrclock,
	input sonic_pkg::tx_oword_u data,
	input logic [sonic_pkg::TX_WRITE_ADDR_WIDTH-1:0] wraddress,
	input logic wren,

	// read port
	input logic rdclock,
	input logic [sonic_pkg::TX_READ_ADDR_WIDTH-1:0] rdaddress,
	output logic [sonic_pkg::BUFFER_WIDTH-1:0] q
);

	// one entry per oword
	sonic_pkg::tx_oword_u mem [(2**sonic_pkg::TX_WRITE_ADDR_WIDTH)-1:0];

	// oword select from the upper qword address bits
	logic [sonic_pkg::TX_WRITE_ADDR_WIDTH-1:0] rd_oword_addr;
	// low or high qword of that oword
	logic rd_qword_sel;

	assign rd_oword_addr = rdaddress[sonic_pkg::TX_READ_ADDR_WIDTH-1:1];
	assign rd_qword_sel = rdaddress[0];

	// --------------------------------------------------
	// write side
	// --------------------------------------------------
	// whole oword stored in one go
	always_ff @(posedge wrclock) begin
		if (wren) begin
			mem[wraddress].oword <= data.oword;
		end
	end

	// --------------------------------------------------
	// read side
	// --------------------------------------------------
	// registered output
	// address in cycle t, qword valid in cycle t+1
	always_ff @(posedge rdclock) begin
		q <= mem[rd_oword_addr].qword[rd_qword_sel];
	end

endmodule

`default_nettype wire

// File: verilog/sonic_fifo_usedw_calculator.sv
// ring fill tracking: write and read pointers, gray crossing both ways, used counts and flags
`timescale 1ns/1ps
`default_nettype none

module sonic_fifo_usedw_calculator (
	input logic wrclock,
	input logic rdclock,
	input logic reset,
	input logic wrreq,
	input logic wrena,
	input logic rdreq,
	input logic rdena,
	output logic [sonic_pkg::USED_QWORDS_WIDTH-1:0] wrusedqwords,
	output logic [sonic_pkg::USED_QWORDS_WIDTH-1:0] rdusedqwords,
	output logic full,
	output logic almost_full,
	output logic empty,
	output logic almost_empty
);

	// gray to binary, msb down
	function automatic logic [sonic_pkg::USED_QWORDS_WIDTH-1:0] gray_to_bin(
		input logic [sonic_pkg::USED_QWORDS_WIDTH-1:0] gray
	);
		logic [sonic_pkg::USED_QWORDS_WIDTH-1:0] bin;
		bin[sonic_pkg::USED_QWORDS_WIDTH-1] = gray[sonic_pkg::USED_QWORDS_WIDTH-1];
		for (int i = sonic_pkg::USED_QWORDS_WIDTH - 2; i >= 0; i--) begin
			bin[i] = bin[i+1] ^ gray[i];
		end
		return bin;
	endfunction

	// write pointer kept in owords
	// a push is always 2 qwords so the gray code stays one bit per step
	logic wr_push;
	logic [sonic_pkg::USED_QWORDS_WIDTH-2:0] wrptr_owords;
	logic [sonic_pkg::USED_QWORDS_WIDTH-2:0] wrptr_owords_next;
	logic [sonic_pkg::USED_QWORDS_WIDTH-2:0] wrptr_gray;
	// read pointer seen from wrclock
	logic [sonic_pkg::USED_QWORDS_WIDTH-1:0] rdptr_gray_meta;
	logic [sonic_pkg::USED_QWORDS_WIDTH-1:0] rdptr_gray_sync;

	// read pointer kept in qwords
	logic rd_pop;
	logic [sonic_pkg::USED_QWORDS_WIDTH-1:0] rdptr_qwords;
	logic [sonic_pkg::USED_QWORDS_WIDTH-1:0] rdptr_qwords_next;
	logic [sonic_pkg::USED_QWORDS_WIDTH-1:0] rdptr_gray;
	// write pointer seen from rdclock
	logic [sonic_pkg::USED_QWORDS_WIDTH-2:0] wrptr_gray_meta;
	logic [sonic_pkg::USED_QWORDS_WIDTH-2:0] wrptr_gray_sync;
	logic [sonic_pkg::USED_QWORDS_WIDTH-1:0] wrptr_sync_bin;

	// --------------------------------------------------
	// wrclock domain
	// --------------------------------------------------
	assign wr_push = wrreq & wrena;
	assign wrptr_owords_next = wrptr_owords + 1'b1;

	always_ff @(posedge wrclock or posedge reset) begin
		if (reset) begin
			wrptr_owords <= '0;
			wrptr_gray <= '0;
			rdptr_gray_meta <= '0;
			rdptr_gray_sync <= '0;
		end else begin
			if (wr_push) begin
				wrptr_owords <= wrptr_owords_next;
				wrptr_gray <= wrptr_owords_next ^ (wrptr_owords_next >> 1);
			end
			// two flop synchronizer
			rdptr_gray_meta <= rdptr_gray;
			rdptr_gray_sync <= rdptr_gray_meta;
		end
	end

	// pessimistic count, lagging reads
	assign wrusedqwords = {wrptr_owords, 1'b0} - gray_to_bin(rdptr_gray_sync);

	assign full = (wrusedqwords == sonic_pkg::RING_DEPTH_QWORDS);
	assign almost_full = (wrusedqwords >= sonic_pkg::ALMOST_FULL_QWORDS);

	// --------------------------------------------------
	// rdclock domain
	// --------------------------------------------------
	assign rd_pop = rdreq & rdena;
	assign rdptr_qwords_next = rdptr_qwords + 1'b1;

	always_ff @(posedge rdclock or posedge reset) begin
		if (reset) begin
			rdptr_qwords <= '0;
			rdptr_gray <= '0;
			wrptr_gray_meta <= '0;
			wrptr_gray_sync <= '0;
		end else begin
			if (rd_pop) begin
				rdptr_qwords <= rdptr_qwords_next;
				rdptr_gray <= rdptr_qwords_next ^ (rdptr_qwords_next >> 1);
			end
			wrptr_gray_meta <= wrptr_gray;
			wrptr_gray_sync <= wrptr_gray_meta;
		end
	end

	// leading zero keeps the gray value intact
	assign wrptr_sync_bin = gray_to_bin({1'b0, wrptr_gray_sync});
	// owords back to qwords
	assign rdusedqwords = {wrptr_sync_bin[sonic_pkg::USED_QWORDS_WIDTH-2:0], 1'b0}
		- rdptr_qwords;

	assign empty = (rdusedqwords == '0);
	assign almost_empty = (rdusedqwords <= sonic_pkg::ALMOST_EMPTY_QWORDS);

endmodule

`default_nettype wire

// File: verilog/sonic_signal_clock_crosser.sv
// moves a single cycle strobe from one clock to another as a toggle, one pulse out per pulse in
`timescale 1ns/1ps
`default_nettype none

module sonic_signal_clock_crosser (
	input logic inclock,
	input logic outclock,
	input logic reset,
	input logic data,
	output logic q
);

	// flips once per input strobe
	logic in_toggle;
	// synchronizer, bit 0 samples first
	logic [sonic_pkg::CPL_SYNC_STAGES-1:0] sync_chain;
	// last settled toggle level
	logic out_toggle_d;

	// --------------------------------------------------
	// source side
	// --------------------------------------------------
	always_ff @(posedge inclock or posedge reset) begin
		if (reset) begin
			in_toggle <= 1'b0;
		end else if (data) begin
			in_toggle <= ~in_toggle;
		end
	end

	// --------------------------------------------------
	// destination side
	// --------------------------------------------------
	always_ff @(posedge outclock or posedge reset) begin
		if (reset) begin
			sync_chain <= '0;
			out_toggle_d <= 1'b0;
		end else begin
			sync_chain <= {sync_chain[sonic_pkg::CPL_SYNC_STAGES-2:0], in_toggle};
			out_toggle_d <= sync_chain[sonic_pkg::CPL_SYNC_STAGES-1];
		end
	end

	// any level change is one strobe
	assign q = sync_chain[sonic_pkg::CPL_SYNC_STAGES-1] ^ out_toggle_d;

endmodule

`default_nettype wire

// File: verilog/sonic_tx_read_control.sv
// read side control: releases completed qwords to the gearbox and steps the ring read pointer
`timescale 1ns/1ps
`default_nettype none

module sonic_tx_read_control (
	input logic rdclock,
	input logic reset,
	input logic rd_tag_cpl,
	input logic [sonic_pkg::USED_QWORDS_WIDTH-1:0] rdusedqwords,
	input logic gearbox_rdreq,
	output logic [sonic_pkg::TX_READ_ADDR_WIDTH-1:0] rdptr_qwords,
	output logic rd_pop,
	output logic gearbox_ena
);

	// qwords released by the last tag and not yet taken
	logic [sonic_pkg::USED_QWORDS_WIDTH-1:0] cpld_qword_count;
	logic [sonic_pkg::USED_QWORDS_WIDTH-1:0] cpld_qword_count_next;
	// registered, always equal to a nonzero count
	logic rdreq;

	// a qword leaves the ring this cycle
	assign rd_pop = rdreq & gearbox_rdreq;

	// --------------------------------------------------
	// completed qword count
	// --------------------------------------------------
	always_comb begin
		cpld_qword_count_next = cpld_qword_count;
		if (rd_tag_cpl) begin
			// rdusedqwords still holds the qword popped now
			if (rd_pop && (rdusedqwords != '0)) begin
				cpld_qword_count_next = rdusedqwords - 1'b1;
			end else begin
				cpld_qword_count_next = rdusedqwords;
			end
		end else if (gearbox_rdreq && (cpld_qword_count != '0)) begin
			// saturates at zero
			cpld_qword_count_next = cpld_qword_count - 1'b1;
		end
	end

	always_ff @(posedge rdclock or posedge reset) begin
		if (reset) begin
			cpld_qword_count <= '0;
			rdreq <= 1'b0;
			rdptr_qwords <= '0;
			gearbox_ena <= 1'b0;
		end else begin
			cpld_qword_count <= cpld_qword_count_next;
			rdreq <= (cpld_qword_count_next != '0);
			// pointer wraps with the ring
			if (rd_pop) begin
				rdptr_qwords <= rdptr_qwords + 1'b1;
			end
			// ram read takes one cycle
			gearbox_ena <= rdreq;
		end
	end

endmodule

`default_nettype wire

// File: gearbox/sonic_downstream_gearbox.sv
// 64 to 40 bit gearbox feeding the serializer, pulls qwords from the ring as its residue runs low
`timescale 1ns/1ps
`default_nettype none

module sonic_downstream_gearbox (
	input logic rdclock,
	input logic reset,
	input logic ena,
	input logic [sonic_pkg::BUFFER_WIDTH-1:0] data_in,
	output logic rdreq,
	output logic [sonic_pkg::OUTPUT_WIDTH-1:0] data_out,
	output logic data_valid
);

	// held bits, lsb leaves first
	logic [sonic_pkg::GEARBOX_RESIDUE_WIDTH-1:0] residue;
	logic [sonic_pkg::GEARBOX_COUNT_WIDTH-1:0] residue_bits;
	// a qword was asked for last cycle
	logic rdreq_d;

	// qword lands this cycle
	logic take_qword;
	// residue plus any fresh qword
	logic [sonic_pkg::GEARBOX_RESIDUE_WIDTH-1:0] stream;
	logic [sonic_pkg::GEARBOX_COUNT_WIDTH-1:0] stream_bits;
	logic [sonic_pkg::GEARBOX_RESIDUE_WIDTH-1:0] data_in_ext;
	// 40 bits go out this cycle
	logic shift_out;
	logic [sonic_pkg::GEARBOX_RESIDUE_WIDTH-1:0] residue_next;
	logic [sonic_pkg::GEARBOX_COUNT_WIDTH-1:0] residue_bits_next;

	// --------------------------------------------------
	// merge
	// --------------------------------------------------
	// ena is the delayed grant so both together mean the qword is on data_in
	assign take_qword = ena & rdreq_d;
	assign data_in_ext = {
		{(sonic_pkg::GEARBOX_RESIDUE_WIDTH - sonic_pkg::BUFFER_WIDTH){1'b0}},
		data_in
	};

	always_comb begin
		stream = residue;
		stream_bits = residue_bits;
		if (take_qword) begin
			// new qword stacked above the held bits
			stream = residue | (data_in_ext << residue_bits);
			stream_bits = residue_bits + sonic_pkg::GEARBOX_COUNT_WIDTH'(sonic_pkg::BUFFER_WIDTH);
		end
	end

	// --------------------------------------------------
	// split
	// --------------------------------------------------
	// drains leftover words after the last qword too
	assign shift_out = (stream_bits >= sonic_pkg::GEARBOX_COUNT_WIDTH'(sonic_pkg::OUTPUT_WIDTH));

	always_comb begin
		residue_next = stream;
		residue_bits_next = stream_bits;
		if (shift_out) begin
			residue_next = stream >> sonic_pkg::OUTPUT_WIDTH;
			residue_bits_next = stream_bits
				- sonic_pkg::GEARBOX_COUNT_WIDTH'(sonic_pkg::OUTPUT_WIDTH);
		end
	end

	// ask early, the qword shows up next cycle
	assign rdreq = (residue_bits_next
		< sonic_pkg::GEARBOX_COUNT_WIDTH'(sonic_pkg::OUTPUT_WIDTH));

	always_ff @(posedge rdclock or posedge reset) begin
		if (reset) begin
			residue <= '0;
			residue_bits <= '0;
			rdreq_d <= 1'b0;
			data_valid <= 1'b0;
		end else begin
			// upper bits stay zero for the next merge
			residue <= residue_next;
			residue_bits <= residue_bits_next;
			rdreq_d <= rdreq;
			data_valid <= shift_out;
		end
	end

	// output word
	always_ff @(posedge rdclock) begin
		if (shift_out) begin
			data_out <= stream[sonic_pkg::OUTPUT_WIDTH-1:0];
		end
	end

endmodule

`default_nettype wire

// File: verilog/sonic_tx_circular_buffer.sv
// top of the tx circular buffer, host owords in on wrclock and 40 bit words out on rdclock
`timescale 1ns/1ps
`default_nettype none

module sonic_tx_circular_buffer (
	// host write side, wrclock
	input logic [sonic_pkg::INPUT_WIDTH-1:0] write_data,
	input logic [sonic_pkg::TX_WRITE_ADDR_WIDTH-1:0] wr_address_owords,
	input logic wrena,
	input logic wrreq,
	// starts the read side
	input logic tag_cpl,
	// link read side, rdclock
	input logic rdena,

	input logic reset,
	input logic rdclock,
	input logic wrclock,

	output logic [sonic_pkg::OUTPUT_WIDTH-1:0] data_out,
	output logic data_valid,

	// fill monitors
	output logic full,
	output logic almost_full,
	output logic empty,
	output logic almost_empty
);

	logic wr_write;
	logic [sonic_pkg::TX_READ_ADDR_WIDTH-1:0] rdptr_qwords;
	logic [sonic_pkg::BUFFER_WIDTH-1:0] dpram_q;
	logic [sonic_pkg::USED_QWORDS_WIDTH-1:0] rdusedqwords;
	logic rd_tag_cpl;
	logic rd_pop;
	logic gearbox_rdreq;
	logic gearbox_ena;

	// --------------------------------------------------
	// write path
	// --------------------------------------------------
	// same strobe for ram and pointer
	assign wr_write = wrena & wrreq;

	sonic_dpram_async i_dpram (
		.wrclock(wrclock),
		.data(write_data),
		.wraddress(wr_address_owords),
		.wren(wr_write),
		.rdclock(rdclock),
		.rdaddress(rdptr_qwords),
		.q(dpram_q)
	);

	// write side count only feeds the flags
	sonic_fifo_usedw_calculator i_usedw_calculator (
		.wrclock(wrclock),
		.rdclock(rdclock),
		.reset(reset),
		.wrreq(wrreq),
		.wrena(wrena),
		.rdreq(rd_pop),
		.rdena(rdena),
		.wrusedqwords(),
		.rdusedqwords(rdusedqwords),
		.full(full),
		.almost_full(almost_full),
		.empty(empty),
		.almost_empty(almost_empty)
	);

	// --------------------------------------------------
	// completion and read path
	// --------------------------------------------------
	sonic_signal_clock_crosser i_cpl_crosser (
		.inclock(wrclock),
		.outclock(rdclock),
		.reset(reset),
		.data(tag_cpl),
		.q(rd_tag_cpl)
	);

	sonic_tx_read_control i_read_control (
		.rdclock(rdclock),
		.reset(reset),
		.rd_tag_cpl(rd_tag_cpl),
		.rdusedqwords(rdusedqwords),
		.gearbox_rdreq(gearbox_rdreq),
		.rdptr_qwords(rdptr_qwords),
		.rd_pop(rd_pop),
		.gearbox_ena(gearbox_ena)
	);

	sonic_downstream_gearbox i_gearbox (
		.rdclock(rdclock),
		.reset(reset),
		.ena(gearbox_ena),
		.data_in(dpram_q),
		.rdreq(gearbox_rdreq),
		.data_out(data_out),
		.data_valid(data_valid)
	);

endmodule

`default_nettype wire

// File: testbench/sonic_tx_circular_buffer_assertions.sv
// concurrent checks on flags, read pointer and gearbox output bound into the tx circular buffer top
`timescale 1ns/1ps
`default_nettype none

module sonic_tx_circular_buffer_assertions (
	input logic rdclock,
	input logic reset,
	input logic full,
	input logic empty,
	input logic data_valid,
	input logic gearbox_ena,
	input logic [sonic_pkg::TX_READ_ADDR_WIDTH-1:0] rdptr_qwords
);

	// --------------------------------------------------
	// fill flags
	// --------------------------------------------------
	full_not_empty: assert property (@(posedge rdclock) disable iff (reset)
		!(full && empty))
		else $error("full and empty high together");

	// --------------------------------------------------
	// read path
	// --------------------------------------------------
	// gearbox_ena is rdreq one cycle late, so a step needs it high now
	ptr_moves_on_rdreq: assert property (@(posedge rdclock) disable iff (reset)
		(rdptr_qwords != $past(rdptr_qwords)) |-> gearbox_ena)
		else $error("read pointer moved with rdreq low");

	// at most one drain word after the last fresh qword
	valid_after_ena: assert property (@(posedge rdclock) disable iff (reset)
		data_valid |-> ($past(gearbox_ena, 1) || $past(gearbox_ena, 2)))
		else $error("data_valid without recent gearbox_ena");

endmodule

bind sonic_tx_circular_buffer sonic_tx_circular_buffer_assertions i_assertions (
	.rdclock(rdclock),
	.reset(reset),
	.full(full),
	.empty(empty),
	.data_valid(data_valid),
	.gearbox_ena(gearbox_ena),
	.rdptr_qwords(rdptr_qwords)
);

`default_nettype wire

// File: testbench/sonic_tx_circular_buffer_tb.sv
// table driven testbench for the tx circular buffer checked against a bit stream model
`timescale 1ns/1ps
`default_nettype none

module sonic_tx_circular_buffer_tb;

	// --------------------------------------------------
	// stimulus table
	// --------------------------------------------------
	localparam int NUM_ROWS = 7;
	// owords written by each row
	int row_owords [NUM_ROWS] = '{3, 1, 14, 16, 5, 3, 7};
	// tag_cpl pulse after the writes
	bit row_tag [NUM_ROWS] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1};
	// write side flags once the row is in the ring
	bit row_almost_full [NUM_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
	bit row_full [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
	string row_name [NUM_ROWS] = '{
		"write_no_tag", "release_first", "almost_full", "full_ring",
		"hold_until_tag", "continue_stream", "wrap_drain"
	};

	logic wrclock = 1'b0;
	logic rdclock = 1'b0;
	logic reset;
	logic [sonic_pkg::INPUT_WIDTH-1:0] write_data;
	logic [sonic_pkg::TX_WRITE_ADDR_WIDTH-1:0] wr_address_owords;
	logic wrena;
	logic wrreq;
	logic tag_cpl;
	logic rdena;
	logic [sonic_pkg::OUTPUT_WIDTH-1:0] data_out;
	logic data_valid;
	logic full;
	logic almost_full;
	logic empty;
	logic almost_empty;

	// reference stream with bit 0 of the first oword at the front
	logic model_bits [$];
	// next ring slot for the writer
	logic [sonic_pkg::TX_WRITE_ADDR_WIDTH-1:0] wr_addr = '0;
	int error_count = 0;
	int failed_tests = 0;
	int words_seen = 0;
	// words the released bits allow so far
	int words_allowed = 0;
	int released_bits = 0;
	// written but not yet tagged
	int pending_bits = 0;

	always #5 wrclock = ~wrclock;
	always #4 rdclock = ~rdclock;

	sonic_tx_circular_buffer i_sonic_tx_circular_buffer (
		.write_data(write_data),
		.wr_address_owords(wr_address_owords),
		.wrena(wrena),
		.wrreq(wrreq),
		.tag_cpl(tag_cpl),
		.rdena(rdena),
		.reset(reset),
		.rdclock(rdclock),
		.wrclock(wrclock),
		.data_out(data_out),
		.data_valid(data_valid),
		.full(full),
		.almost_full(almost_full),
		.empty(empty),
		.almost_empty(almost_empty)
	);

	// --------------------------------------------------
	// checks and waits
	// --------------------------------------------------
	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			$display("mismatch %s: got %0h, expected %0h", name, actual, expected);
			error_count++;
		end
	endtask

	task automatic wait_rd_cycles(input int count);
		repeat (count) @(posedge rdclock);
	endtask

	// sampled on the falling edge away from both rising edges
	task automatic wait_for_empty(input logic level, input int limit);
		int cycles = 0;
		@(negedge rdclock);
		while ((empty !== level) && (cycles < limit)) begin
			@(negedge rdclock);
			cycles++;
		end
		if (empty !== level) begin
			$display("timeout: empty did not go to %0d within %0d cycles", level, limit);
			error_count++;
		end
	endtask

	task automatic wait_for_words(input int target, input int limit);
		int cycles = 0;
		while ((words_seen < target) && (cycles < limit)) begin
			@(posedge rdclock);
			cycles++;
		end
		if (words_seen < target) begin
			$display("timeout: only %0d of %0d output words arrived", words_seen, target);
			error_count++;
		end
	endtask

	task automatic check_flags(input logic exp_full, input logic exp_almost_full,
		input logic exp_empty, input logic exp_almost_empty);
		@(negedge rdclock);
		check_value("full", 64'(full), 64'(exp_full));
		check_value("almost_full", 64'(almost_full), 64'(exp_almost_full));
		check_value("empty", 64'(empty), 64'(exp_empty));
		check_value("almost_empty", 64'(almost_empty), 64'(exp_almost_empty));
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			$display("test %-16s ok", name);
		end else begin
			$display("test %-16s failed", name);
			failed_tests++;
		end
	endtask

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	// consecutive owords at the writer's pointer with the model following in bit order
	task automatic write_owords(input int count);
		logic [sonic_pkg::INPUT_WIDTH-1:0] word;
		for (int n = 0; n < count; n++) begin
			word = {$urandom, $urandom, $urandom, $urandom};
			@(posedge wrclock);
			write_data <= word;
			wr_address_owords <= wr_addr;
			wrena <= 1'b1;
			wrreq <= 1'b1;
			wr_addr = wr_addr + 1'b1;
			for (int b = 0; b < sonic_pkg::INPUT_WIDTH; b++) begin
				model_bits.push_back(word[b]);
			end
		end
		@(posedge wrclock);
		wrena <= 1'b0;
		wrreq <= 1'b0;
		pending_bits += count * sonic_pkg::INPUT_WIDTH;
	endtask

	// one wrclock strobe releases everything written so far
	task automatic pulse_tag();
		@(posedge wrclock);
		tag_cpl <= 1'b1;
		@(posedge wrclock);
		tag_cpl <= 1'b0;
		released_bits += pending_bits;
		pending_bits = 0;
		words_allowed = released_bits / sonic_pkg::OUTPUT_WIDTH;
	endtask

	// --------------------------------------------------
	// output monitor
	// --------------------------------------------------
	task automatic collect_word();
		logic [sonic_pkg::OUTPUT_WIDTH-1:0] expected;
		expected = '0;
		if (words_seen >= words_allowed) begin
			$display("data_valid pulsed with no released word left to send");
			error_count++;
		end else begin
			for (int b = 0; b < sonic_pkg::OUTPUT_WIDTH; b++) begin
				expected[b] = model_bits.pop_front();
			end
			check_value("data_out", 64'(data_out), 64'(expected));
		end
		words_seen++;
	endtask

	always @(negedge rdclock) begin
		if (!reset && data_valid) begin
			collect_word();
		end
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	task automatic check_reset_state();
		int errors_before;
		errors_before = error_count;
		wait_rd_cycles(4);
		check_flags(1'b0, 1'b0, 1'b1, 1'b1);
		check_value("data_valid", 64'(data_valid), 64'd0);
		report_test("reset_state", errors_before);
	endtask

	task automatic run_row(input int r);
		int errors_before;
		int pending_qwords;
		errors_before = error_count;
		write_owords(row_owords[r]);
		pending_qwords = pending_bits / sonic_pkg::BUFFER_WIDTH;
		wait_for_empty(1'b0, 20);
		// tag must trail the last write by at least 12 rdclock cycles
		wait_rd_cycles(16);
		check_flags(row_full[r], row_almost_full[r], 1'b0,
			pending_qwords <= int'(sonic_pkg::ALMOST_EMPTY_QWORDS));
		if (row_tag[r]) begin
			pulse_tag();
			wait_for_words(words_allowed, 400);
			wait_for_empty(1'b1, 100);
			// room for the read pointer to reach the write side
			wait_rd_cycles(20);
			check_flags(1'b0, 1'b0, 1'b1, 1'b1);
		end else begin
			// held data so the monitor flags any early word
			wait_rd_cycles(40);
		end
		check_value("word_count", 64'(words_seen), 64'(words_allowed));
		report_test(row_name[r], errors_before);
	endtask

	initial begin
		write_data = '0;
		wr_address_owords = '0;
		wrena = 1'b0;
		wrreq = 1'b0;
		tag_cpl = 1'b0;
		rdena = 1'b1;
		reset = 1'b1;
		void'($urandom(32'h1f3d_cffa));
		repeat (16) @(posedge rdclock);
		reset <= 1'b0;

		check_reset_state();
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end

		$display("tests %0d, failed %0d, errors %0d, words %0d", NUM_ROWS + 1,
			failed_tests, error_count, words_seen);
		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sonic_tx_circular_buffer.f
common/sonic_pkg.sv
verilog/sonic_dpram_async.sv
verilog/sonic_fifo_usedw_calculator.sv
verilog/sonic_signal_clock_crosser.sv
verilog/sonic_tx_read_control.sv
gearbox/sonic_downstream_gearbox.sv
verilog/sonic_tx_circular_buffer.sv
testbench/sonic_tx_circular_buffer_assertions.sv
testbench/sonic_tx_circular_buffer_tb.sv

// File: Makefile
# Verilator build and run of the tx circular buffer testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a failing result"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal \
		-f sonic_tx_circular_buffer.f \
		--top-module sonic_tx_circular_buffer_tb \
		-Mdir obj_dir -o sim
	./obj_dir/sim > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
